//--- rtl/byteFifo.sv
`timescale 1ns/1ps
`default_nettype none

module byteFifo #(
	parameter int Depth = matVecPkg::FIFO_DEPTH
) (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         push,
	input  logic [matVecPkg::BYTE_W-1:0] pushData,
	input  logic                         pop,
	input  logic                         flush,
	output logic [matVecPkg::BYTE_W-1:0] popData,
	output logic                         full,
	output logic                         empty
);
	import matVecPkg::*;

	logic [BYTE_W-1:0] mem [Depth];
	logic [$clog2(Depth)-1:0] wrPtr;
	logic [$clog2(Depth)-1:0] rdPtr;
	logic [$clog2(Depth):0] count;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign full = count == Depth;
	assign empty = count == '0;

	// First word falls through
	assign popData = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
		else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

//--- rtl/decimalFormatter.sv
`timescale 1ns/1ps
`default_nettype none

module decimalFormatter (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [matVecPkg::BYTE_W-1:0] resultByte,
	input  logic                         resultValid,
	output logic                         resultReady,
	output logic [matVecPkg::BYTE_W-1:0] outByte,
	output logic                         outValid,
	input  logic                         outReady
);
	import matVecPkg::*;

	logic [1:0] state;
	logic [1:0] digitIdx;
	logic [BYTE_W-1:0] rem;
	logic [3:0] hund;
	logic [3:0] tens;
	logic [3:0] digit;

	assign resultReady = state == FS_IDLE;
	assign outValid = state == FS_SEND;

	// Hundreds, tens, then whatever is left as ones
	always_comb begin
		case (digitIdx)
			2'd0: digit = hund;
			2'd1: digit = tens;
			default: digit = rem[3:0];
		endcase
	end

	assign outByte = CHAR_0 + BYTE_W'(digit);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= FS_IDLE;
			digitIdx <= '0;
		end else begin
			case (state)
				FS_IDLE: begin
					digitIdx <= '0;
					if (resultValid)
						state <= FS_HUND;
				end
				FS_HUND: begin
					if (rem < 8'd100)
						state <= FS_TENS;
				end
				FS_TENS: begin
					if (rem < 8'd10)
						state <= FS_SEND;
				end
				FS_SEND: begin
					if (outReady) begin
						digitIdx <= digitIdx + 2'd1;
						if (digitIdx == 2'd2)
							state <= FS_IDLE;
					end
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

	// Repeated subtraction, one step per cycle
	always_ff @(posedge clk) begin
		if (state == FS_IDLE && resultValid) begin
			rem <= resultByte;
			hund <= '0;
			tens <= '0;
		end else if (state == FS_HUND && rem >= 8'd100) begin
			rem <= rem - 8'd100;
			hund <= hund + 4'd1;
		end else if (state == FS_TENS && rem >= 8'd10) begin
			rem <= rem - 8'd10;
			tens <= tens + 4'd1;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outByte))
		else $error("digit withdrawn before transfer");

endmodule

`default_nettype wire

//--- rtl/frameParser.sv
`timescale 1ns/1ps
`default_nettype none

module frameParser (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [matVecPkg::BYTE_W-1:0] inByte,
	input  logic                         inValid,
	output logic                         inReady,
	input  logic                         fifoFull,
	input  logic                         engineBusy,
	output logic                         fifoPush,
	output logic [matVecPkg::BYTE_W-1:0] fifoData,
	output logic                         fifoFlush,
	output logic                         computeStart,
	output logic [matVecPkg::N_W-1:0]    matN,
	output logic                         frameError
);
	import matVecPkg::*;

	logic [3:0] state;
	logic [3:0] nextState;
	logic fail;
	logic accept;
	logic hexOk;
	logic [3:0] nibble;
	logic [3:0] hiNib;
	logic [BYTE_W-1:0] pairByte;
	logic [BYTE_W-1:0] lenReg;
	logic [BYTE_W-1:0] cmdReg;
	logic [BYTE_W-1:0] pairCnt;
	logic [BYTE_W-1:0] loadLen;
	logic [N_W-1:0] pendingN;

	// Uppercase hex digits only
	function automatic logic isHex(input logic [BYTE_W-1:0] c);
		return (c >= CHAR_0 && c <= CHAR_0 + 8'd9) || (c >= CHAR_A && c <= CHAR_F);
	endfunction

	function automatic logic [3:0] hexVal(input logic [BYTE_W-1:0] c);
		logic [BYTE_W-1:0] v;
		if (c >= CHAR_A)
			v = c - CHAR_A + 8'd10;
		else
			v = c - CHAR_0;
		return v[3:0];
	endfunction

	assign accept = inValid && inReady;
	assign hexOk = isHex(inByte);
	assign nibble = hexVal(inByte);
	assign pairByte = {hiNib, nibble};
	assign loadLen = BYTE_W'(matN) + BYTE_W'(matN) * BYTE_W'(matN);

	// Stall while the FIFO is full or a computation is in progress
	assign inReady = !fifoFull && !engineBusy && !computeStart;

	assign fifoPush = accept && state == PS_DATA_LO && hexOk && cmdReg == CMD_LOAD;
	assign fifoData = pairByte;
	assign fifoFlush = frameError;

	always_comb begin
		nextState = state;
		fail = 1'b0;
		case (state)
			PS_HUNT: begin
				if (inByte == CHAR_F)
					nextState = PS_START_E;
			end
			PS_START_E: begin
				if (inByte == CHAR_E)
					nextState = PS_LEN_HI;
				else if (inByte != CHAR_F)
					nextState = PS_HUNT;
			end
			PS_LEN_HI, PS_CMD_HI, PS_DATA_HI: begin
				fail = !hexOk;
				nextState = state + 4'd1;
			end
			PS_LEN_LO: begin
				fail = !hexOk;
				nextState = PS_CMD_HI;
			end
			PS_CMD_LO: begin
				nextState = PS_DATA_HI;
				if (pairByte == CMD_SET_N)
					fail = !hexOk || lenReg != 8'd1;
				else if (pairByte == CMD_LOAD)
					fail = !hexOk || lenReg != loadLen;
				else
					fail = 1'b1;
			end
			PS_DATA_LO: begin
				fail = !hexOk ||
					(cmdReg == CMD_SET_N && (pairByte == '0 || pairByte > MAX_N));
				nextState = (pairCnt == lenReg - 8'd1) ? PS_STOP_E : PS_DATA_HI;
			end
			PS_STOP_E: begin
				fail = inByte != CHAR_E;
				nextState = PS_STOP_F;
			end
			PS_STOP_F: begin
				fail = inByte != CHAR_F;
				nextState = PS_HUNT;
			end
			default: nextState = PS_HUNT;
		endcase
		if (fail)
			nextState = PS_HUNT;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= PS_HUNT;
			matN <= N_W'(DEFAULT_N);
			frameError <= 1'b0;
			computeStart <= 1'b0;
		end else begin
			frameError <= accept && fail;
			computeStart <= accept && !fail && state == PS_STOP_F && cmdReg == CMD_LOAD;
			if (accept) begin
				state <= nextState;
				// N changes only once the whole set-N frame has checked out
				if (!fail && state == PS_STOP_F && cmdReg == CMD_SET_N)
					matN <= pendingN;
			end
		end
	end

	// Field registers
	always_ff @(posedge clk) begin
		if (accept) begin
			case (state)
				PS_LEN_HI, PS_CMD_HI, PS_DATA_HI: hiNib <= nibble;
				PS_LEN_LO: lenReg <= pairByte;
				PS_CMD_LO: begin
					cmdReg <= pairByte;
					pairCnt <= '0;
				end
				PS_DATA_LO: begin
					pairCnt <= pairCnt + 8'd1;
					pendingN <= pairByte[N_W-1:0];
				end
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) fifoPush |-> !fifoFull)
		else $error("payload push into a full FIFO");

endmodule

`default_nettype wire

//--- rtl/matVecEngine.sv
`timescale 1ns/1ps
`default_nettype none

module matVecEngine (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         computeStart,
	input  logic [matVecPkg::N_W-1:0]    matN,
	input  logic [matVecPkg::BYTE_W-1:0] fifoOut,
	input  logic                         fifoEmpty,
	output logic                         fifoPop,
	output logic [matVecPkg::BYTE_W-1:0] resultByte,
	output logic                         resultValid,
	input  logic                         resultReady,
	output logic                         engineBusy
);
	import matVecPkg::*;

	logic [1:0] state;
	logic [N_W-1:0] nReg;
	logic [IDX_W-1:0] elemCnt;
	logic [IDX_W-1:0] rowCnt;
	logic [IDX_W-1:0] lastIdx;
	logic lastElem;
	logic [BYTE_W-1:0] vecReg [MAX_N];
	logic [BYTE_W-1:0] acc;
	logic [BYTE_W-1:0] macBase;
	logic [BYTE_W-1:0] macNext;

	assign lastIdx = IDX_W'(nReg - 1'b1);
	assign lastElem = elemCnt == lastIdx;

	// Pop whenever data is there, except while a row result waits
	assign fifoPop = (state == ES_VEC || state == ES_ROW) && !fifoEmpty;

	// First product of a row starts a fresh sum, wrapping mod 256
	assign macBase = (elemCnt == '0) ? '0 : acc;
	assign macNext = macBase + fifoOut * vecReg[elemCnt];

	assign resultByte = acc;
	assign resultValid = state == ES_PRESENT;
	assign engineBusy = state != ES_IDLE;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= ES_IDLE;
			nReg <= N_W'(DEFAULT_N);
			elemCnt <= '0;
			rowCnt <= '0;
		end else begin
			case (state)
				ES_IDLE: begin
					if (computeStart) begin
						// Size is fixed for the whole computation
						nReg <= matN;
						elemCnt <= '0;
						rowCnt <= '0;
						state <= ES_VEC;
					end
				end
				ES_VEC, ES_ROW: begin
					if (fifoPop) begin
						if (lastElem) begin
							elemCnt <= '0;
							state <= (state == ES_VEC) ? ES_ROW : ES_PRESENT;
						end else begin
							elemCnt <= elemCnt + 1'b1;
						end
					end
				end
				ES_PRESENT: begin
					if (resultReady) begin
						if (rowCnt == lastIdx) begin
							state <= ES_IDLE;
						end else begin
							rowCnt <= rowCnt + 1'b1;
							state <= ES_ROW;
						end
					end
				end
				default: state <= ES_IDLE;
			endcase
		end
	end

	// Vector register file and row accumulator
	always_ff @(posedge clk) begin
		if (state == ES_VEC && fifoPop)
			vecReg[elemCnt] <= fifoOut;
		if (state == ES_ROW && fifoPop)
			acc <= macNext;
	end

	assert property (@(posedge clk) disable iff (!rstN)
		resultValid && !resultReady |=> resultValid && $stable(resultByte))
		else $error("row result changed before the formatter took it");

endmodule

`default_nettype wire

//--- rtl/matVecPkg.sv
`default_nettype none

package matVecPkg;

	// Stream and matrix sizes
	localparam int BYTE_W = 8;
	localparam int MAX_N = 8;
	localparam int DEFAULT_N = 2;
	localparam int N_W = $clog2(MAX_N + 1);
	localparam int IDX_W = $clog2(MAX_N);

	// Payload capacity, at least MAX_N + MAX_N * MAX_N
	localparam int FIFO_DEPTH = 128;

	// ASCII characters used by the frame and the decimal output
	localparam logic [BYTE_W-1:0] CHAR_F = 8'd70;
	localparam logic [BYTE_W-1:0] CHAR_E = 8'd69;
	localparam logic [BYTE_W-1:0] CHAR_0 = 8'd48;
	localparam logic [BYTE_W-1:0] CHAR_A = 8'd65;

	// Command codes
	localparam logic [BYTE_W-1:0] CMD_SET_N = 8'd1;
	localparam logic [BYTE_W-1:0] CMD_LOAD = 8'd2;

	// Parser states, each low nibble state directly after its high one
	localparam logic [3:0] PS_HUNT = 4'd0;
	localparam logic [3:0] PS_START_E = 4'd1;
	localparam logic [3:0] PS_LEN_HI = 4'd2;
	localparam logic [3:0] PS_LEN_LO = 4'd3;
	localparam logic [3:0] PS_CMD_HI = 4'd4;
	localparam logic [3:0] PS_CMD_LO = 4'd5;
	localparam logic [3:0] PS_DATA_HI = 4'd6;
	localparam logic [3:0] PS_DATA_LO = 4'd7;
	localparam logic [3:0] PS_STOP_E = 4'd8;
	localparam logic [3:0] PS_STOP_F = 4'd9;

	// Engine states
	localparam logic [1:0] ES_IDLE = 2'd0;
	localparam logic [1:0] ES_VEC = 2'd1;
	localparam logic [1:0] ES_ROW = 2'd2;
	localparam logic [1:0] ES_PRESENT = 2'd3;

	// Formatter states
	localparam logic [1:0] FS_IDLE = 2'd0;
	localparam logic [1:0] FS_HUND = 2'd1;
	localparam logic [1:0] FS_TENS = 2'd2;
	localparam logic [1:0] FS_SEND = 2'd3;

endpackage

`default_nettype wire

//--- rtl/matVecTop.sv
`timescale 1ns/1ps
`default_nettype none

module matVecTop (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [matVecPkg::BYTE_W-1:0] inByte,
	input  logic                         inValid,
	output logic                         inReady,
	output logic [matVecPkg::BYTE_W-1:0] outByte,
	output logic                         outValid,
	input  logic                         outReady,
	output logic                         frameError
);
	import matVecPkg::*;

	// Parser to FIFO
	logic fifoPush;
	logic [BYTE_W-1:0] fifoData;
	logic fifoFlush;
	logic fifoFull;
	logic fifoEmpty;

	// FIFO and parser to engine
	logic fifoPop;
	logic [BYTE_W-1:0] fifoOut;
	logic computeStart;
	logic [N_W-1:0] matN;
	logic engineBusy;

	// Engine to formatter
	logic [BYTE_W-1:0] resultByte;
	logic resultValid;
	logic resultReady;

	frameParser parser (
		.clk(clk),
		.rstN(rstN),
		.inByte(inByte),
		.inValid(inValid),
		.inReady(inReady),
		.fifoFull(fifoFull),
		.engineBusy(engineBusy),
		.fifoPush(fifoPush),
		.fifoData(fifoData),
		.fifoFlush(fifoFlush),
		.computeStart(computeStart),
		.matN(matN),
		.frameError(frameError)
	);

	byteFifo #(.Depth(FIFO_DEPTH)) payloadFifo (
		.clk(clk),
		.rstN(rstN),
		.push(fifoPush),
		.pushData(fifoData),
		.pop(fifoPop),
		.flush(fifoFlush),
		.popData(fifoOut),
		.full(fifoFull),
		.empty(fifoEmpty)
	);

	matVecEngine engine (
		.clk(clk),
		.rstN(rstN),
		.computeStart(computeStart),
		.matN(matN),
		.fifoOut(fifoOut),
		.fifoEmpty(fifoEmpty),
		.fifoPop(fifoPop),
		.resultByte(resultByte),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.engineBusy(engineBusy)
	);

	decimalFormatter formatter (
		.clk(clk),
		.rstN(rstN),
		.resultByte(resultByte),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.outByte(outByte),
		.outValid(outValid),
		.outReady(outReady)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f verilog.f --top-module tbMatVec -o simMatVec &&
./obj_dir/simMatVec | tee sim.log
grep -q "^STATUS: PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- test/tbMatVec.sv
`timescale 1ns/1ps
`default_nettype none

module tbMatVec;
	import matVecPkg::*;

	localparam logic [31:0] SEED = 32'hd614;

	logic clk;
	logic rstN;
	logic [7:0] inByte;
	logic inValid;
	logic inReady;
	logic [7:0] outByte;
	logic outValid;
	logic outReady;
	logic frameError;

	logic [31:0] rngIn;
	logic [31:0] rngOut;
	logic [7:0] expQ [$];
	int modelN;
	int bytesSent;
	int cycleCount;
	int errorCount;
	int digitsChecked;
	int errExpected;
	int errSeen;

	matVecTop DUT (
		.clk(clk),
		.rstN(rstN),
		.inByte(inByte),
		.inValid(inValid),
		.inReady(inReady),
		.outByte(outByte),
		.outValid(outValid),
		.outReady(outReady),
		.frameError(frameError)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int unsigned randBelow(input int unsigned limit);
		rngIn = lcgStep(rngIn);
		return (rngIn >> 16) % limit;
	endfunction

	// ASCII '0'..'9' then 'A'..'F'
	function automatic logic [7:0] hexChar(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		return 8'h37 + {4'h0, nib};
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		if (expected != actual) begin
			errorCount++;
			$display("ERROR %s: expected %0d, actual %0d", what, expected, actual);
		end
	endtask

	task automatic reportAndFinish(input bit timedOut);
		$display("Closing: %0d errors, %0d digits checked, frameError pulses %0d of %0d",
			errorCount, digitsChecked, errSeen, errExpected);
		if (timedOut || errorCount != 0)
			$display("STATUS: FAIL");
		else
			$display("STATUS: PASS");
		$finish;
	endtask

	// One byte with an optional idle gap in front, returns on the transfer edge
	task automatic sendByte(input logic [7:0] b);
		int gap;
		gap = (randBelow(4) == 0) ? 1 + int'(randBelow(3)) : 0;
		repeat (gap) begin
			@(negedge clk);
			inValid = 1'b0;
		end
		@(negedge clk);
		inByte = b;
		inValid = 1'b1;
		while (!inReady)
			@(negedge clk);
		@(posedge clk);
		bytesSent++;
	endtask

	task automatic idleInput();
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic sendHex(input logic [7:0] b);
		sendByte(hexChar(b[7:4]));
		sendByte(hexChar(b[3:0]));
	endtask

	task automatic sendHeader(input logic [7:0] len, input logic [7:0] cmd);
		sendByte(CHAR_F);
		sendByte(CHAR_E);
		sendHex(len);
		sendHex(cmd);
	endtask

	task automatic expectDigits(input logic [7:0] v);
		expQ.push_back(8'h30 + v / 8'd100);
		expQ.push_back(8'h30 + (v / 8'd10) % 8'd10);
		expQ.push_back(8'h30 + v % 8'd10);
	endtask

	// Junk outside a frame, which the parser must ignore
	task automatic sendNoise();
		logic [7:0] c;
		int count;
		count = randBelow(4);
		repeat (count) begin
			c = 8'(randBelow(128));
			sendByte(c == CHAR_F ? 8'h2e : c);
		end
		if (randBelow(2) == 0) begin
			c = 8'(randBelow(128));
			sendByte(CHAR_F);
			sendByte((c == CHAR_E || c == CHAR_F) ? 8'h23 : c);
		end
	endtask

	task automatic sendSetN(input int n);
		sendHeader(8'd1, CMD_SET_N);
		sendHex(8'(n));
		if (n >= 1 && n <= MAX_N) begin
			sendByte(CHAR_E);
			sendByte(CHAR_F);
			modelN = n;
		end else begin
			errExpected++;
		end
	endtask

	// Mode 0 good, 1 wrong stop marker, 2 non-hex character in the payload
	task automatic sendLoad(input int mode);
		logic [7:0] vec [MAX_N];
		logic [7:0] rowSums [MAX_N];
		logic [7:0] elem;
		int n;
		int total;
		int breakAt;
		n = modelN;
		total = n + n * n;
		breakAt = randBelow(total);
		for (int i = 0; i < MAX_N; i++)
			rowSums[i] = 8'd0;
		sendHeader(8'(total), CMD_LOAD);
		for (int k = 0; k < total; k++) begin
			if (mode == 2 && k == breakAt) begin
				sendByte(8'h5a);
				errExpected++;
				return;
			end
			elem = 8'(randBelow(256));
			sendHex(elem);
			if (k < n)
				vec[k] = elem;
			else
				rowSums[(k - n) / n] = rowSums[(k - n) / n] + elem * vec[(k - n) % n];
		end
		if (mode == 1) begin
			sendByte(CHAR_E);
			sendByte(CHAR_E);
			errExpected++;
		end else begin
			for (int i = 0; i < n; i++)
				expectDigits(rowSums[i]);
			sendByte(CHAR_E);
			sendByte(CHAR_F);
		end
	endtask

	task automatic sendBadFrame(input int kind);
		logic [7:0] cmd;
		case (kind)
			0: sendLoad(1);
			1: begin
				cmd = 8'(randBelow(256));
				if (cmd == CMD_SET_N || cmd == CMD_LOAD)
					cmd = 8'h7e;
				sendHeader(8'd1, cmd);
				errExpected++;
			end
			2: begin
				sendHeader(8'(modelN + modelN * modelN + 1), CMD_LOAD);
				errExpected++;
			end
			3: sendSetN(0);
			4: sendSetN(MAX_N + 1);
			default: sendLoad(2);
		endcase
	endtask

	// Output side, random back-pressure and digit check
	always @(negedge clk) begin
		rngOut = lcgStep(rngOut);
		outReady = (rngOut[31:16] % 3) != 0;
		if (rstN && outValid && outReady) begin
			if (expQ.size() == 0) begin
				errorCount++;
				$display("Unexpected output byte %0d with no digit pending", outByte);
			end else begin
				checkValue($sformatf("digit %0d", digitsChecked), int'(expQ[0]), int'(outByte));
				void'(expQ.pop_front());
			end
			digitsChecked++;
		end
		if (rstN && frameError)
			errSeen++;
	end

	// Limit grows with the number of bytes sent so far
	initial begin
		cycleCount = 0;
		while (cycleCount <= 20 * bytesSent + 2000) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles with %0d digits still pending",
			cycleCount, expQ.size());
		reportAndFinish(1'b1);
	end

	initial begin
		rngIn = SEED;
		rngOut = ~SEED;
		rstN = 1'b0;
		inByte = 8'd0;
		inValid = 1'b0;
		outReady = 1'b0;
		modelN = DEFAULT_N;
		bytesSent = 0;
		errorCount = 0;
		digitsChecked = 0;
		errExpected = 0;
		errSeen = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Size after reset
		sendNoise();
		sendLoad(0);

		// Every size once, then random sizes
		for (int round = 0; round < 14; round++) begin
			sendNoise();
			sendSetN(round < MAX_N ? round + 1 : 1 + int'(randBelow(MAX_N)));
			sendNoise();
			sendLoad(0);
			sendNoise();
			sendBadFrame(round % 6);
			sendNoise();
			sendLoad(0);
		end
		idleInput();

		while (expQ.size() != 0 || !inReady)
			@(negedge clk);
		// Quiet period to catch stray digits or error pulses
		repeat (10) @(negedge clk);
		checkValue("frameError pulses", errExpected, errSeen);
		reportAndFinish(1'b0);
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/matVecPkg.sv
rtl/byteFifo.sv
rtl/frameParser.sv
rtl/matVecEngine.sv
rtl/decimalFormatter.sv
rtl/matVecTop.sv
test/tbMatVec.sv
